// File: hdl/sif_pkg.sv
package sif_pkg;

	// -------------------------------------------------------------------------
	// Datapath widths
	// -------------------------------------------------------------------------

	// Interleaved I/Q drive word from the controller
	localparam int DRIVE_W = 18;

	// Held I and Q words, top 16 drive bits plus one sign bit of headroom
	localparam int IQ_W = 17;

	// Every LO component, both the input LO and the generated ones
	localparam int LO_W = 18;

	// One DAC word, two of them per clock
	localparam int DAC_W = 16;

	// Symmetric clip limit of a DAC word, the most negative code is never sent
	localparam int DAC_MAX = (2 ** (DAC_W - 1)) - 1;

	// -------------------------------------------------------------------------
	// LO band select codes
	// -------------------------------------------------------------------------

	// High band, rotated and interpolated input LO
	localparam logic LO_SEL_145 = 1'b0;
	// Low band, table LO times input LO
	localparam logic LO_SEL_60 = 1'b1;

	// -------------------------------------------------------------------------
	// Scaling
	// -------------------------------------------------------------------------

	// 1/16 step used as a small-angle phase advance
	localparam int INTERP_SHIFT = 4;
	// Mixer sum back to DAC scale
	localparam int LVL_SHIFT = 17;
	// Complex product back to LO scale
	localparam int MUL_SHIFT = 17;

	// -------------------------------------------------------------------------
	// Low-band table
	// -------------------------------------------------------------------------

	// One full LO period, addresses 0 to 32
	localparam int LUT_LEN = 33;
	localparam int LUT_AW = 6;

endpackage

// File: hdl/iq_interp.sv
module iq_interp import sif_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic [1:0]             i_div_state,
	input  logic signed [DRIVE_W-1:0] i_drive,
	output logic signed [IQ_W-1:0] o_drive_i,
	output logic signed [IQ_W-1:0] o_drive_q
);

	// Top 16 drive bits, the two LSBs carry no useful resolution
	logic signed [IQ_W-2:0] drive_top;
	// Same value with one extra sign bit
	logic signed [IQ_W-1:0] drive_ext;
	// High on the cycle that carries a Q sample
	logic                   q_slot;

	assign drive_top = i_drive[DRIVE_W-1:DRIVE_W-IQ_W+1];
	assign drive_ext = IQ_W'(drive_top);
	assign q_slot    = i_div_state[0];

	// Demultiplex the stream
	// Each word is loaded on its own slot and held through the other one,
	// so the mixers see both I and Q on every clock
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_drive_i <= '0;
			o_drive_q <= '0;
		end else begin
			if (q_slot) begin
				o_drive_q <= drive_ext;
			end else begin
				o_drive_i <= drive_ext;
			end
		end
	end

endmodule

// File: hdl/lo_145_gen.sv
module lo_145_gen import sif_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic [1:0]             i_div_state,
	input  logic signed [LO_W-1:0] i_cosa,
	input  logic signed [LO_W-1:0] i_sina,
	output logic signed [LO_W-1:0] o_cos1,
	output logic signed [LO_W-1:0] o_sin1,
	output logic signed [LO_W-1:0] o_cos2,
	output logic signed [LO_W-1:0] o_sin2
);

	// Input LO after the quarter-rate rotation
	logic signed [LO_W-1:0] cos_rot;
	logic signed [LO_W-1:0] sin_rot;

	// -------------------------------------------------------------------------
	// Quarter-rate rotation
	// -------------------------------------------------------------------------

	// Multiply by i^state to move the 7/33 LO up by a quarter of the clock
	// Bit inversion stands in for negation, off by one LSB
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cos_rot <= '0;
			sin_rot <= '0;
		end else begin
			case (i_div_state)
				2'd0: cos_rot <= i_cosa;
				2'd1: cos_rot <= ~i_sina;
				2'd2: cos_rot <= ~i_cosa;
				default: cos_rot <= i_sina;
			endcase
			case (i_div_state)
				2'd0: sin_rot <= i_sina;
				2'd1: sin_rot <= i_cosa;
				2'd2: sin_rot <= ~i_sina;
				default: sin_rot <= ~i_cosa;
			endcase
		end
	end

	// -------------------------------------------------------------------------
	// DDR interpolation
	// -------------------------------------------------------------------------

	// Phase 1 is the rotated LO times (1 + i/16)
	// Phase 2 is the rotated LO times (i + 1/16), a quarter turn further on
	// 1/16 approximates the small extra phase step between DDR samples
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_cos1 <= '0;
			o_sin1 <= '0;
			o_cos2 <= '0;
			o_sin2 <= '0;
		end else begin
			o_cos1 <= cos_rot - (sin_rot >>> INTERP_SHIFT);
			o_sin1 <= sin_rot + (cos_rot >>> INTERP_SHIFT);
			o_cos2 <= ~sin_rot + (cos_rot >>> INTERP_SHIFT);
			o_sin2 <= cos_rot + (sin_rot >>> INTERP_SHIFT);
		end
	end

	// Rotation is only correct if the divider steps once per clock
	a_div_step: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_div_state == $past(i_div_state) + 2'd1)
		else $error("div_state skipped, now %0d", i_div_state);

endmodule

// File: hdl/lo_lut.sv
module lo_lut import sif_pkg::*; (
	input  logic                   clk,
	input  logic [LUT_AW-1:0]      i_addr,
	output logic signed [LO_W-1:0] o_cos,
	output logic signed [LO_W-1:0] o_sin
);

	// Packed {cos, sin} for the addressed step
	logic [2*LO_W-1:0] rom_v;

	// One period of exp(j*2*pi*k/33), amplitude 2^17-1
	// Second half mirrors the first with sine negated
	always_comb begin
		case (i_addr)
			6'd0:  rom_v = {18'sd131071, 18'sd0};
			6'd1:  rom_v = {18'sd128702, 18'sd24805};
			6'd2:  rom_v = {18'sd121682, 18'sd48714};
			6'd3:  rom_v = {18'sd110264, 18'sd70862};
			6'd4:  rom_v = {18'sd94861, 18'sd90449};
			6'd5:  rom_v = {18'sd76029, 18'sd106767};
			6'd6:  rom_v = {18'sd54449, 18'sd119226};
			6'd7:  rom_v = {18'sd30901, 18'sd127376};
			6'd8:  rom_v = {18'sd6237, 18'sd130923};
			6'd9:  rom_v = {-18'sd18653, 18'sd129737};
			6'd10: rom_v = {-18'sd42869, 18'sd123862};
			6'd11: rom_v = {-18'sd65536, 18'sd113511};
			6'd12: rom_v = {-18'sd85833, 18'sd99057};
			6'd13: rom_v = {-18'sd103029, 18'sd81023};
			6'd14: rom_v = {-18'sd116501, 18'sd60060};
			6'd15: rom_v = {-18'sd125762, 18'sd36927};
			6'd16: rom_v = {-18'sd130478, 18'sd12459};
			6'd17: rom_v = {-18'sd130478, -18'sd12459};
			6'd18: rom_v = {-18'sd125762, -18'sd36927};
			6'd19: rom_v = {-18'sd116501, -18'sd60060};
			6'd20: rom_v = {-18'sd103029, -18'sd81023};
			6'd21: rom_v = {-18'sd85833, -18'sd99057};
			6'd22: rom_v = {-18'sd65536, -18'sd113511};
			6'd23: rom_v = {-18'sd42869, -18'sd123862};
			6'd24: rom_v = {-18'sd18653, -18'sd129737};
			6'd25: rom_v = {18'sd6237, -18'sd130923};
			6'd26: rom_v = {18'sd30901, -18'sd127376};
			6'd27: rom_v = {18'sd54449, -18'sd119226};
			6'd28: rom_v = {18'sd76029, -18'sd106767};
			6'd29: rom_v = {18'sd94861, -18'sd90449};
			6'd30: rom_v = {18'sd110264, -18'sd70862};
			6'd31: rom_v = {18'sd121682, -18'sd48714};
			6'd32: rom_v = {18'sd128702, -18'sd24805};
			// Unused addresses
			default: rom_v = '0;
		endcase
	end

	// Registered read, maps onto a block ROM
	always_ff @(posedge clk) begin
		o_cos <= rom_v[2*LO_W-1:LO_W];
		o_sin <= rom_v[LO_W-1:0];
	end

endmodule

// File: hdl/cpx_mul.sv
module cpx_mul import sif_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic signed [LO_W-1:0] i_re_a,
	input  logic signed [LO_W-1:0] i_im_a,
	input  logic signed [LO_W-1:0] i_re_b,
	input  logic signed [LO_W-1:0] i_im_b,
	output logic signed [LO_W-1:0] o_re,
	output logic signed [LO_W-1:0] o_im
);

	// Stage 1 partial products, full precision
	logic signed [2*LO_W-1:0] p_rr;
	logic signed [2*LO_W-1:0] p_ii;
	logic signed [2*LO_W-1:0] p_ri;
	logic signed [2*LO_W-1:0] p_ir;

	// Stage 2 sums, one guard bit
	logic signed [2*LO_W:0] sum_re;
	logic signed [2*LO_W:0] sum_im;

	// ---------------------------------------------------------------------------
	// Stage 1, four multipliers
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p_rr <= '0;
			p_ii <= '0;
			p_ri <= '0;
			p_ir <= '0;
		end else begin
			p_rr <= i_re_a * i_re_b;
			p_ii <= i_im_a * i_im_b;
			p_ri <= i_re_a * i_im_b;
			p_ir <= i_im_a * i_re_b;
		end
	end

	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
	assign sum_re = p_rr - p_ii;
	assign sum_im = p_ri + p_ir;

	// Stage 2, scale back to LO range
	// Overflow wraps, the table amplitude keeps unit-magnitude inputs inside
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_re <= '0;
			o_im <= '0;
		end else begin
			o_re <= LO_W'(sum_re >>> MUL_SHIFT);
			o_im <= LO_W'(sum_im >>> MUL_SHIFT);
		end
	end

endmodule

// File: hdl/lo_60_gen.sv
module lo_60_gen import sif_pkg::*; (
	input  logic                   clk,
	input  logic                   i_rst_n,
	input  logic signed [LO_W-1:0] i_cosa,
	input  logic signed [LO_W-1:0] i_sina,
	output logic signed [LO_W-1:0] o_cos1,
	output logic signed [LO_W-1:0] o_sin1,
	output logic signed [LO_W-1:0] o_cos2,
	output logic signed [LO_W-1:0] o_sin2
);

	// Table step for DDR phase 1, and the step after it for phase 2
	logic [LUT_AW-1:0] lut_addr;
	logic [LUT_AW-1:0] lut_addr_nxt;

	// Table outputs
	logic signed [LO_W-1:0] cos_t1;
	logic signed [LO_W-1:0] sin_t1;
	logic signed [LO_W-1:0] cos_t2;
	logic signed [LO_W-1:0] sin_t2;

	// Input LO aligned with the registered table read
	logic signed [LO_W-1:0] cosa_d;
	logic signed [LO_W-1:0] sina_d;

	// Wraps 32 -> 0
	assign lut_addr_nxt = (lut_addr == LUT_AW'(LUT_LEN - 1)) ? '0 : lut_addr + 1'b1;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lut_addr <= '0;
			cosa_d   <= '0;
			sina_d   <= '0;
		end else begin
			lut_addr <= lut_addr_nxt;
			cosa_d   <= i_cosa;
			sina_d   <= i_sina;
		end
	end

	// -------------------------------------------------------------------------
	// Two table reads, two mixes with the input LO
	// -------------------------------------------------------------------------
	lo_lut lut_1_inst (.clk(clk), .i_addr(lut_addr), .o_cos(cos_t1), .o_sin(sin_t1));
	lo_lut lut_2_inst (.clk(clk), .i_addr(lut_addr_nxt), .o_cos(cos_t2), .o_sin(sin_t2));

	cpx_mul mul_1_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_re_a(cos_t1), .i_im_a(sin_t1),
		.i_re_b(cosa_d), .i_im_b(sina_d),
		.o_re(o_cos1), .o_im(o_sin1)
	);

	cpx_mul mul_2_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_re_a(cos_t2), .i_im_a(sin_t2),
		.i_re_b(cosa_d), .i_im_b(sina_d),
		.o_re(o_cos2), .o_im(o_sin2)
	);

	// Out-of-range steps would read zeros from the table
	a_addr_range: assert property (@(posedge clk) disable iff (!i_rst_n)
		lut_addr <= LUT_AW'(LUT_LEN - 1))
		else $error("lut_addr out of range: %0d", lut_addr);

endmodule

// File: hdl/level_mix.sv
module level_mix import sif_pkg::*; (
	input  logic                    clk,
	input  logic                    i_rst_n,
	input  logic signed [IQ_W-1:0]  i_drive_i,
	input  logic signed [IQ_W-1:0]  i_drive_q,
	input  logic signed [LO_W-1:0]  i_cos,
	input  logic signed [LO_W-1:0]  i_sin,
	output logic signed [DAC_W-1:0] o_data
);

	// Registered projections of I and Q
	logic signed [IQ_W+LO_W-1:0] p_i;
	logic signed [IQ_W+LO_W-1:0] p_q;

	// Sum with a guard bit, then scaled and clipped
	logic signed [IQ_W+LO_W:0] sum_iq;
	logic signed [IQ_W+LO_W:0] sum_sh;
	logic signed [IQ_W+LO_W:0] sum_sat;

	// Stage 1, products
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			p_i <= '0;
			p_q <= '0;
		end else begin
			p_i <= i_drive_i * i_cos;
			p_q <= i_drive_q * i_sin;
		end
	end

	assign sum_iq = p_i + p_q;
	assign sum_sh = sum_iq >>> LVL_SHIFT;

	// Symmetric clip, keeps the DAC code range balanced around zero
	always_comb begin
		if (sum_sh > DAC_MAX) begin
			sum_sat = DAC_MAX;
		end else if (sum_sh < -DAC_MAX) begin
			sum_sat = -DAC_MAX;
		end else begin
			sum_sat = sum_sh;
		end
	end

	// Stage 2, registered DAC word
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_data <= '0;
		end else begin
			o_data <= DAC_W'(sum_sat);
		end
	end

	a_no_min_code: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_data != {1'b1, {(DAC_W - 1){1'b0}}})
		else $error("o_data hit the most negative code");

endmodule

// File: hdl/second_if_out.sv
module second_if_out import sif_pkg::*; (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic [1:0]               i_div_state,
	input  logic signed [DRIVE_W-1:0] i_drive,
	input  logic                     i_lo_sel,
	input  logic                     i_enable,
	input  logic signed [LO_W-1:0]   i_cosa,
	input  logic signed [LO_W-1:0]   i_sina,
	output logic signed [DAC_W-1:0]  o_dac_out0,
	output logic signed [DAC_W-1:0]  o_dac_out1
);

	// Full-rate I and Q
	logic signed [IQ_W-1:0] drive_i;
	logic signed [IQ_W-1:0] drive_q;

	// High-band LO pair
	logic signed [LO_W-1:0] cos_h1, sin_h1, cos_h2, sin_h2;
	// Low-band LO pair
	logic signed [LO_W-1:0] cos_l1, sin_l1, cos_l2, sin_l2;
	// Selected LO pair
	logic signed [LO_W-1:0] cos_lo1, sin_lo1, cos_lo2, sin_lo2;

	// Mixer outputs before the enable gate
	logic signed [DAC_W-1:0] mix_out1;
	logic signed [DAC_W-1:0] mix_out2;

	iq_interp iq_interp_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_div_state(i_div_state), .i_drive(i_drive),
		.o_drive_i(drive_i), .o_drive_q(drive_q)
	);

	// -------------------------------------------------------------------------
	// LO generation, both bands run all the time
	// -------------------------------------------------------------------------
	lo_145_gen lo_145_gen_inst (
		.clk(clk), .i_rst_n(i_rst_n), .i_div_state(i_div_state),
		.i_cosa(i_cosa), .i_sina(i_sina),
		.o_cos1(cos_h1), .o_sin1(sin_h1), .o_cos2(cos_h2), .o_sin2(sin_h2)
	);

	lo_60_gen lo_60_gen_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_cosa(i_cosa), .i_sina(i_sina),
		.o_cos1(cos_l1), .o_sin1(sin_l1), .o_cos2(cos_l2), .o_sin2(sin_l2)
	);

	// Band select, low band has one more cycle of latency
	always_comb begin
		case (i_lo_sel)
			LO_SEL_145: begin
				cos_lo1 = cos_h1;
				sin_lo1 = sin_h1;
				cos_lo2 = cos_h2;
				sin_lo2 = sin_h2;
			end
			default: begin
				cos_lo1 = cos_l1;
				sin_lo1 = sin_l1;
				cos_lo2 = cos_l2;
				sin_lo2 = sin_l2;
			end
		endcase
	end

	// -------------------------------------------------------------------------
	// Mixing, one mixer per DDR phase
	// -------------------------------------------------------------------------
	level_mix mix_1_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_drive_i(drive_i), .i_drive_q(drive_q),
		.i_cos(cos_lo1), .i_sin(sin_lo1), .o_data(mix_out1)
	);

	level_mix mix_2_inst (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_drive_i(drive_i), .i_drive_q(drive_q),
		.i_cos(cos_lo2), .i_sin(sin_lo2), .o_data(mix_out2)
	);

	// DAC words, zero while disabled
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_dac_out0 <= '0;
			o_dac_out1 <= '0;
		end else begin
			o_dac_out0 <= i_enable ? mix_out1 : '0;
			o_dac_out1 <= i_enable ? mix_out2 : '0;
		end
	end

endmodule

// File: dv/second_if_out_tb.sv
module second_if_out_tb import sif_pkg::*; ();

	// Phase lengths in clock cycles
	localparam int RST_CYC = 8;
	localparam int IDLE_CYC = 40;
	localparam int GATE_CYC = 80;
	localparam int ZERO_CYC = 160;
	localparam int HIGH_CYC = 600;
	localparam int LOW_CYC = 400;
	localparam int FULL_CYC = 400;
	// Pipeline fill before a check is armed
	localparam int WARM_CYC = 12;
	// Fill plus one whole table period of history
	localparam int PERIOD_WARM_CYC = 60;
	// Register stages from LO sample to high-band DAC word
	localparam int MODEL_LAT = 5;

	// Phase start cycles
	localparam int P_IDLE = RST_CYC;
	localparam int P_GATE = P_IDLE + IDLE_CYC;
	localparam int P_ZERO = P_GATE + GATE_CYC;
	localparam int P_HIGH = P_ZERO + ZERO_CYC;
	localparam int P_LOW = P_HIGH + HIGH_CYC;
	localparam int P_FULL = P_LOW + LOW_CYC;
	localparam int P_END = P_FULL + FULL_CYC;
	// Watchdog limit of 2000 cycles in all
	localparam int MARGIN_CYC = 312;
	localparam int RUN_CYC = P_END + MARGIN_CYC;

	localparam logic [DAC_W-1:0] MIN_CODE = {1'b1, {(DAC_W - 1){1'b0}}};

	logic                      clk = 1'b0;
	logic                      i_rst_n;
	logic [1:0]                i_div_state;
	logic signed [DRIVE_W-1:0] i_drive;
	logic                      i_lo_sel;
	logic                      i_enable;
	logic signed [LO_W-1:0]    i_cosa;
	logic signed [LO_W-1:0]    i_sina;
	logic signed [DAC_W-1:0]   o_dac_out0;
	logic signed [DAC_W-1:0]   o_dac_out1;

	// Sequencer state
	int                  cyc;
	logic [1:0]          div_cnt;
	logic [31:0]         lfsr_state;
	logic [DRIVE_W-1:0]  drv_i_val;
	logic [DRIVE_W-1:0]  drv_q_val;

	// Each check enable arms one group of assertions
	logic chk_zero;
	logic chk_high;
	logic chk_lo;

	// Expected words and past outputs
	logic signed [DAC_W-1:0] exp0_pipe [MODEL_LAT];
	logic signed [DAC_W-1:0] exp1_pipe [MODEL_LAT];
	logic signed [DAC_W-1:0] hist0 [LUT_LEN];
	logic signed [DAC_W-1:0] hist1 [LUT_LEN];

	int err_zero;
	int err_gate;
	int err_model;
	int err_period;
	int err_min;

	second_if_out second_if_out_inst (
		.clk(clk), .i_rst_n(i_rst_n), .i_div_state(i_div_state), .i_drive(i_drive),
		.i_lo_sel(i_lo_sel), .i_enable(i_enable), .i_cosa(i_cosa), .i_sina(i_sina),
		.o_dac_out0(o_dac_out0), .o_dac_out1(o_dac_out1)
	);

	always #20 clk = ~clk;

	// ---------------------------------------------------------------------------
	// Random source and reference model
	// ---------------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < nbits; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// High-band LO by quarter-turn steps with one's-complement negation
	task automatic high_lo_model(input logic [1:0] st, input logic signed [LO_W-1:0] c, s,
		output logic signed [LO_W-1:0] c1, s1, c2, s2);
		logic signed [LO_W-1:0] rc;
		logic signed [LO_W-1:0] rs;
		case (st)
			2'd0: begin
				rc = c;
				rs = s;
			end
			2'd1: begin
				rc = ~s;
				rs = c;
			end
			2'd2: begin
				rc = ~c;
				rs = ~s;
			end
			default: begin
				rc = s;
				rs = ~c;
			end
		endcase
		// Phase 1 is times (1 + i/16) and phase 2 times (i + 1/16)
		c1 = rc - (rs >>> INTERP_SHIFT);
		s1 = rs + (rc >>> INTERP_SHIFT);
		c2 = ~rs + (rc >>> INTERP_SHIFT);
		s2 = rc + (rs >>> INTERP_SHIFT);
	endtask

	// I cos + Q sin scaled and clipped symmetrically
	function automatic logic signed [DAC_W-1:0] mix_model(input logic [DRIVE_W-1:0] di, dq,
		input logic signed [LO_W-1:0] c, s);
		longint iv;
		longint qv;
		longint acc;
		iv = longint'($signed(di[DRIVE_W-1:2]));
		qv = longint'($signed(dq[DRIVE_W-1:2]));
		acc = (iv * c + qv * s) >>> LVL_SHIFT;
		if (acc > DAC_MAX) begin
			acc = DAC_MAX;
		end else if (acc < -DAC_MAX) begin
			acc = -DAC_MAX;
		end
		return DAC_W'(acc);
	endfunction

	// Model runs on the inputs the DUT samples
	always @(posedge clk) begin : model_step
		logic signed [LO_W-1:0] mc1;
		logic signed [LO_W-1:0] ms1;
		logic signed [LO_W-1:0] mc2;
		logic signed [LO_W-1:0] ms2;
		high_lo_model(i_div_state, i_cosa, i_sina, mc1, ms1, mc2, ms2);
		exp0_pipe[0] <= mix_model(drv_i_val, drv_q_val, mc1, ms1);
		exp1_pipe[0] <= mix_model(drv_i_val, drv_q_val, mc2, ms2);
		for (int j = 1; j < MODEL_LAT; j++) begin
			exp0_pipe[j] <= exp0_pipe[j-1];
			exp1_pipe[j] <= exp1_pipe[j-1];
		end
		// Past outputs kept for the period check
		hist0[0] <= o_dac_out0;
		hist1[0] <= o_dac_out1;
		for (int j = 1; j < LUT_LEN; j++) begin
			hist0[j] <= hist0[j-1];
			hist1[j] <= hist1[j-1];
		end
	end

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------

	a_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
		chk_zero |-> (o_dac_out0 == '0 && o_dac_out1 == '0))
		else begin
			err_zero = err_zero + 1;
			$display("CHECK FAILED o_dac_out0 = %h, o_dac_out1 = %h, expected 0000",
				$sampled(o_dac_out0), $sampled(o_dac_out1));
		end

	// Disabled output is zero one cycle on
	a_gate: assert property (@(posedge clk) disable iff (!i_rst_n)
		!i_enable |=> (o_dac_out0 == '0 && o_dac_out1 == '0))
		else begin
			err_gate = err_gate + 1;
			$display("CHECK FAILED o_dac_out0 = %h, o_dac_out1 = %h while disabled",
				$sampled(o_dac_out0), $sampled(o_dac_out1));
		end

	a_model0: assert property (@(posedge clk) disable iff (!i_rst_n)
		chk_high |-> o_dac_out0 == exp0_pipe[MODEL_LAT-1])
		else begin
			err_model = err_model + 1;
			$display("CHECK FAILED o_dac_out0 = %h, expected %h",
				$sampled(o_dac_out0), $sampled(exp0_pipe[MODEL_LAT-1]));
		end

	a_model1: assert property (@(posedge clk) disable iff (!i_rst_n)
		chk_high |-> o_dac_out1 == exp1_pipe[MODEL_LAT-1])
		else begin
			err_model = err_model + 1;
			$display("CHECK FAILED o_dac_out1 = %h, expected %h",
				$sampled(o_dac_out1), $sampled(exp1_pipe[MODEL_LAT-1]));
		end

	// Low band repeats once per table period
	a_period: assert property (@(posedge clk) disable iff (!i_rst_n)
		chk_lo |-> (o_dac_out0 == hist0[LUT_LEN-1] && o_dac_out1 == hist1[LUT_LEN-1]))
		else begin
			err_period = err_period + 1;
			$display("CHECK FAILED o_dac_out0 = %h (was %h), o_dac_out1 = %h (was %h)",
				$sampled(o_dac_out0), $sampled(hist0[LUT_LEN-1]),
				$sampled(o_dac_out1), $sampled(hist1[LUT_LEN-1]));
		end

	a_min_code: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_dac_out0 != MIN_CODE && o_dac_out1 != MIN_CODE)
		else begin
			err_min = err_min + 1;
			$display("CHECK FAILED o_dac_out0 = %h, o_dac_out1 = %h, most negative code %h",
				$sampled(o_dac_out0), $sampled(o_dac_out1), MIN_CODE);
		end

	// ---------------------------------------------------------------------------
	// Stimulus steps once per falling edge
	// ---------------------------------------------------------------------------

	initial begin
		i_rst_n = 1'b0;
		i_div_state = 2'd0;
		i_drive = '0;
		i_lo_sel = LO_SEL_145;
		i_enable = 1'b0;
		i_cosa = '0;
		i_sina = '0;
		cyc = 0;
		div_cnt = 2'd0;
		lfsr_state = 32'h9cef;
		drv_i_val = '0;
		drv_q_val = '0;
		chk_zero = 1'b0;
		chk_high = 1'b0;
		chk_lo = 1'b0;
		err_zero = 0;
		err_gate = 0;
		err_model = 0;
		err_period = 0;
		err_min = 0;
	end

	always @(negedge clk) begin
		cyc = cyc + 1;
		if (cyc == P_END) begin
			$display("Error counts: zero %0d, gate %0d, model %0d, period %0d, min code %0d",
				err_zero, err_gate, err_model, err_period, err_min);
			if (err_zero + err_gate + err_model + err_period + err_min == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end else begin
			// Divider keeps stepping through reset
			div_cnt = div_cnt + 2'd1;
			i_div_state = div_cnt;
			if (cyc >= P_IDLE && cyc < P_GATE) begin
				// Idle after reset with no drive yet
				i_rst_n = 1'b1;
				i_enable = 1'b1;
				chk_zero = 1'b1;
				i_cosa = LO_W'(rand_bits(LO_W));
				i_sina = LO_W'(rand_bits(LO_W));
			end else if (cyc >= P_GATE && cyc < P_ZERO) begin
				// Everything random while enable toggles
				chk_zero = 1'b0;
				i_enable = 1'(rand_bits(1));
				i_lo_sel = 1'(rand_bits(1));
				drv_i_val = DRIVE_W'(rand_bits(DRIVE_W));
				drv_q_val = DRIVE_W'(rand_bits(DRIVE_W));
				i_cosa = LO_W'(rand_bits(LO_W));
				i_sina = LO_W'(rand_bits(LO_W));
			end else if (cyc >= P_ZERO && cyc < P_HIGH) begin
				// Zero drive in both bands
				i_enable = 1'b1;
				drv_i_val = '0;
				drv_q_val = '0;
				i_lo_sel = (cyc < P_ZERO + ZERO_CYC / 2) ? LO_SEL_145 : LO_SEL_60;
				chk_zero = (cyc >= P_ZERO + WARM_CYC);
				i_cosa = LO_W'(rand_bits(LO_W));
				i_sina = LO_W'(rand_bits(LO_W));
			end else if (cyc >= P_HIGH && cyc < P_LOW) begin
				// High band against the model
				if (cyc == P_HIGH) begin
					chk_zero = 1'b0;
					drv_i_val = DRIVE_W'(rand_bits(DRIVE_W));
					drv_q_val = DRIVE_W'(rand_bits(DRIVE_W));
				end
				i_lo_sel = LO_SEL_145;
				chk_high = (cyc >= P_HIGH + WARM_CYC);
				i_cosa = LO_W'(rand_bits(LO_W));
				i_sina = LO_W'(rand_bits(LO_W));
			end else if (cyc >= P_LOW && cyc < P_FULL) begin
				// Low band with constant LO and drive
				if (cyc == P_LOW) begin
					chk_high = 1'b0;
					drv_i_val = DRIVE_W'(rand_bits(DRIVE_W));
					drv_q_val = DRIVE_W'(rand_bits(DRIVE_W));
					i_cosa = LO_W'(rand_bits(LO_W));
					i_sina = LO_W'(rand_bits(LO_W));
				end
				i_lo_sel = LO_SEL_60;
				chk_lo = (cyc >= P_LOW + PERIOD_WARM_CYC);
			end else if (cyc >= P_FULL) begin
				// Full-scale drive pushes the mixers into the clip
				chk_lo = 1'b0;
				drv_i_val = 18'h1ffff;
				drv_q_val = 18'h20000;
				if (cyc < P_FULL + FULL_CYC / 2) begin
					i_lo_sel = LO_SEL_145;
					chk_high = (cyc >= P_FULL + WARM_CYC);
					i_cosa = LO_W'(rand_bits(LO_W));
					i_sina = LO_W'(rand_bits(LO_W));
				end else begin
					i_lo_sel = LO_SEL_60;
					chk_high = 1'b0;
					i_cosa = 18'h20000;
					i_sina = 18'h20000;
				end
			end
			// Bit 0 of the divider picks the Q slot
			i_drive = div_cnt[0] ? drv_q_val : drv_i_val;
		end
	end

	// Watchdog
	initial begin
		repeat (RUN_CYC) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", RUN_CYC);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: second_if_out.f
hdl/sif_pkg.sv
hdl/iq_interp.sv
hdl/lo_145_gen.sv
hdl/lo_lut.sv
hdl/cpx_mul.sv
hdl/lo_60_gen.sv
hdl/level_mix.sv
hdl/second_if_out.sv
dv/second_if_out_tb.sv

// File: Makefile
# Verilator simulation of the second-IF upconverter

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= second_if_out_tb
FILELIST  ?= second_if_out.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

# Build, run, then decide pass or fail from the log
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
